/* hdl/fp_mul_settings.svh */
`ifndef FP_MUL_SETTINGS_SVH
`define FP_MUL_SETTINGS_SVH

// single precision field widths
`define FP_EXP_W    8
`define FP_FRAC_W   23
`define FP_EXP_BIAS 127

// canonical quiet nan
`define FP_QNAN     32'h7fc00000

// register stages in the pipeline
`define FP_LATENCY  3

`endif

/* hdl/fp_mul_pkg.sv */
`default_nettype none
`include "fp_mul_settings.svh"

package fp_mul_pkg;

    localparam int SIG_W     = `FP_FRAC_W + 1;
    localparam int PROD_W    = 2 * SIG_W;
    localparam int NORM_W    = SIG_W + 3;
    localparam int EXP_SUM_W = `FP_EXP_W + 2;

    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp32_t;

    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } rmode_e;

    typedef logic [PROD_W-1:0] sig_prod_t;
    // hidden bit, fraction, guard, round, sticky
    typedef logic [NORM_W-1:0] sig_norm_t;
    typedef logic signed [EXP_SUM_W-1:0] exp_sum_t;

endpackage

`default_nettype wire

/* hdl/fp_mul_unpack.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_mul_unpack (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  fp_mul_pkg::fp32_t  fp_x,
    input  fp_mul_pkg::fp32_t  fp_y,
    input  fp_mul_pkg::rmode_e r_mode,
    output logic               s1_valid,
    output fp_mul_pkg::fp32_t  s1_x,
    output fp_mul_pkg::fp32_t  s1_y,
    output fp_mul_pkg::rmode_e s1_rmode,
    output logic               s1_x_zero,
    output logic               s1_x_inf,
    output logic               s1_x_nan,
    output logic               s1_y_zero,
    output logic               s1_y_inf,
    output logic               s1_y_nan
);

    // exponent field all ones
    logic x_top;
    logic y_top;

    assign x_top = &fp_x.exp;
    assign y_top = &fp_y.exp;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // zero exponent flushes subnormals to zero
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_x      <= fp_x;
            s1_y      <= fp_y;
            s1_rmode  <= r_mode;
            s1_x_zero <= (fp_x.exp == '0);
            s1_x_inf  <= x_top && (fp_x.frac == '0);
            s1_x_nan  <= x_top && (fp_x.frac != '0);
            s1_y_zero <= (fp_y.exp == '0);
            s1_y_inf  <= y_top && (fp_y.frac == '0);
            s1_y_nan  <= y_top && (fp_y.frac != '0);
        end
    end

endmodule

`default_nettype wire

/* hdl/fp_mul_booth.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fp_mul_settings.svh"

module fp_mul_booth (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  s1_valid,
    input  logic [`FP_FRAC_W-1:0] frc_x,
    input  logic [`FP_FRAC_W-1:0] frc_y,
    output logic                  s2_valid,
    output fp_mul_pkg::sig_prod_t s2_prod
);

    import fp_mul_pkg::*;

    localparam int PP_W   = SIG_W + 2;
    localparam int DIGITS = (SIG_W + 2) / 2;

    logic [SIG_W-1:0]  mcand;
    logic [2*DIGITS:0] mplier;
    logic [PP_W-1:0]   pp_one;
    logic [PP_W-1:0]   pp_two;
    logic [PP_W-1:0]   pp;
    logic [2:0]        digit;
    sig_prod_t         acc;

    assign mcand  = {1'b1, frc_x};
    // two zero bits on top keep the multiplier unsigned
    assign mplier = {2'b00, 1'b1, frc_y, 1'b0};
    assign pp_one = {2'b00, mcand};
    assign pp_two = {1'b0, mcand, 1'b0};

    // one signed digit per overlapping triplet
    always_comb begin
        acc   = '0;
        pp    = '0;
        digit = '0;
        for (int i = 0; i < DIGITS; i++) begin
            digit = mplier[2*i +: 3];
            case (digit)
                3'b001, 3'b010: pp = pp_one;
                3'b011:         pp = pp_two;
                3'b100:         pp = -pp_two;
                3'b101, 3'b110: pp = -pp_one;
                default:        pp = '0;
            endcase
            // sum wraps mod 2^48 but the final product is positive
            acc = acc + ({{(PROD_W-PP_W){pp[PP_W-1]}}, pp} << (2*i));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_prod <= acc;
    end

endmodule

`default_nettype wire

/* hdl/fp_mul_exp.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fp_mul_settings.svh"

module fp_mul_exp (
    input  logic                 clk,
    input  logic                 rst,
    input  fp_mul_pkg::fp32_t    s1_x,
    input  fp_mul_pkg::fp32_t    s1_y,
    input  fp_mul_pkg::rmode_e   s1_rmode,
    input  logic                 s1_x_zero,
    input  logic                 s1_x_inf,
    input  logic                 s1_x_nan,
    input  logic                 s1_y_zero,
    input  logic                 s1_y_inf,
    input  logic                 s1_y_nan,
    output fp_mul_pkg::fp32_t    s2_x,
    output fp_mul_pkg::fp32_t    s2_y,
    output fp_mul_pkg::rmode_e   s2_rmode,
    output fp_mul_pkg::exp_sum_t s2_exp_sum,
    output logic                 s2_sign,
    output logic                 s2_special,
    output fp_mul_pkg::fp32_t    s2_special_val
);

    import fp_mul_pkg::*;

    logic     sign;
    logic     any_nan;
    logic     any_inf;
    logic     any_zero;
    exp_sum_t exp_sum;
    fp32_t    special_val;

    assign sign     = s1_x.sign ^ s1_y.sign;
    assign any_nan  = s1_x_nan || s1_y_nan;
    assign any_inf  = s1_x_inf || s1_y_inf;
    assign any_zero = s1_x_zero || s1_y_zero;
    assign exp_sum  = exp_sum_t'(s1_x.exp) + exp_sum_t'(s1_y.exp)
                    - exp_sum_t'(`FP_EXP_BIAS);

    always_comb begin
        special_val.sign = sign;
        special_val.exp  = '0;
        special_val.frac = '0;
        // inf times zero gives the quiet nan like a nan operand
        if (any_nan || (any_inf && any_zero)) begin
            special_val = `FP_QNAN;
        end else if (any_inf) begin
            special_val.exp = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_special <= 1'b0;
        end else begin
            s2_special <= any_nan || any_inf || any_zero;
        end
    end

    always_ff @(posedge clk) begin
        s2_x           <= s1_x;
        s2_y           <= s1_y;
        s2_rmode       <= s1_rmode;
        s2_exp_sum     <= exp_sum;
        s2_sign        <= sign;
        s2_special_val <= special_val;
    end

endmodule

`default_nettype wire

/* hdl/fp_mul_norm.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_mul_norm (
    input  fp_mul_pkg::sig_prod_t s2_prod,
    output fp_mul_pkg::sig_norm_t norm_sig,
    output logic                  norm_n
);

    import fp_mul_pkg::*;

    // hidden bit, fraction, guard and round
    localparam int KEEP_W = NORM_W - 1;

    sig_prod_t shifted;

    // product of two [1,2) values lies in [1,4)
    assign norm_n = s2_prod[PROD_W-1];

    assign shifted = norm_n ? s2_prod : {s2_prod[PROD_W-2:0], 1'b0};

    // dropped low bits collapse into sticky
    assign norm_sig = {shifted[PROD_W-1 -: KEEP_W], |shifted[PROD_W-KEEP_W-1:0]};

endmodule

`default_nettype wire

/* hdl/fp_mul_round.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fp_mul_settings.svh"

module fp_mul_round (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  s2_valid,
    input  fp_mul_pkg::sig_norm_t norm_sig,
    input  logic                  norm_n,
    input  fp_mul_pkg::exp_sum_t  s2_exp_sum,
    input  logic                  s2_sign,
    input  fp_mul_pkg::rmode_e    s2_rmode,
    input  logic                  s2_special,
    input  fp_mul_pkg::fp32_t     s2_special_val,
    output logic                  out_valid,
    output fp_mul_pkg::fp32_t     fp_z,
    output logic                  ovrf,
    output logic                  udrf,
    output logic [`FP_FRAC_W-1:0] frc_z,
    output logic                  norm_r,
    output logic [`FP_EXP_W-1:0]  exp_z
);

    import fp_mul_pkg::*;

    logic [SIG_W-1:0] sig_trunc;
    logic [SIG_W:0]   sig_rnd;
    logic             lsb;
    logic             guard;
    logic             sticky;
    logic             inc;
    logic             ovf;
    logic             udf;
    exp_sum_t         exp_fin;
    fp32_t            z_next;

    assign sig_trunc = norm_sig[NORM_W-1 -: SIG_W];
    assign lsb       = norm_sig[3];
    assign guard     = norm_sig[2];
    assign sticky    = norm_sig[1] | norm_sig[0];

    always_comb begin
        case (s2_rmode)
            RNE:     inc = guard && (sticky || lsb);
            RDN:     inc = s2_sign && (guard || sticky);
            RUP:     inc = !s2_sign && (guard || sticky);
            RMM:     inc = guard;
            // rtz, spare codes truncate too
            default: inc = 1'b0;
        endcase
    end

    assign sig_rnd = {1'b0, sig_trunc} + {{SIG_W{1'b0}}, inc};
    assign norm_r  = sig_rnd[SIG_W];
    // on carry out the fraction is already all zero
    assign frc_z   = sig_rnd[`FP_FRAC_W-1:0];
    assign exp_fin = s2_exp_sum + exp_sum_t'(norm_n) + exp_sum_t'(norm_r);
    assign exp_z   = exp_fin[`FP_EXP_W-1:0];
    assign ovf     = exp_fin >= exp_sum_t'(2**`FP_EXP_W - 1);
    assign udf     = exp_fin <= exp_sum_t'(0);

    always_comb begin
        z_next.sign = s2_sign;
        z_next.exp  = exp_z;
        z_next.frac = frc_z;
        if (s2_special) begin
            z_next = s2_special_val;
        end else if (ovf) begin
            z_next.exp  = '1;
            z_next.frac = '0;
        end else if (udf) begin
            z_next.exp  = '0;
            z_next.frac = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            ovrf      <= 1'b0;
            udrf      <= 1'b0;
        end else begin
            out_valid <= s2_valid;
            ovrf      <= s2_valid && !s2_special && ovf;
            udrf      <= s2_valid && !s2_special && udf;
        end
    end

    always_ff @(posedge clk) begin
        fp_z <= z_next;
    end

endmodule

`default_nettype wire

/* hdl/fp_mul_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fp_mul_settings.svh"

module fp_mul_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  s2_valid,
    input  fp_mul_pkg::fp32_t     s2_x,
    input  fp_mul_pkg::fp32_t     s2_y,
    input  fp_mul_pkg::sig_prod_t s2_prod,
    input  fp_mul_pkg::sig_norm_t norm_sig,
    input  logic                  norm_n,
    input  logic                  norm_r,
    input  logic                  s2_sign,
    input  logic                  s2_special,
    input  logic [`FP_FRAC_W-1:0] frc_z,
    input  logic [`FP_EXP_W-1:0]  exp_z,
    output logic                  check_error
);

    import fp_mul_pkg::*;

    sig_prod_t        prod_ref;
    sig_prod_t        prod_shift;
    sig_norm_t        norm_ref;
    logic [SIG_W-1:0] frc_step;
    exp_sum_t         exp_ref;
    logic             in_range;
    logic             bad_booth;
    logic             bad_norm;
    logic             bad_lead;
    logic             bad_sign;
    logic             bad_round;
    logic             bad_exp;

    assign prod_ref  = {1'b1, s2_x.frac} * {1'b1, s2_y.frac};
    assign bad_booth = (s2_prod != prod_ref);

    // normalize from the booth output so stages are checked apart
    assign prod_shift = s2_prod[PROD_W-1] ? s2_prod : (s2_prod << 1);
    assign norm_ref   = {prod_shift[PROD_W-1 -: NORM_W-1], prod_shift[PROD_W-NORM_W:0] != '0};
    assign bad_norm   = (norm_n != s2_prod[PROD_W-1]) || (norm_sig != norm_ref);
    assign bad_lead   = !norm_sig[NORM_W-1];
    assign bad_sign   = (s2_sign != (s2_x.sign ^ s2_y.sign));

    // rounding adds zero or one to the truncated fraction
    assign frc_step  = {norm_r, frc_z} - {1'b0, norm_sig[NORM_W-2 -: `FP_FRAC_W]};
    assign bad_round = (frc_step > 1);

    assign exp_ref  = exp_sum_t'(s2_x.exp) + exp_sum_t'(s2_y.exp)
                    - exp_sum_t'(`FP_EXP_BIAS) + exp_sum_t'(norm_n) + exp_sum_t'(norm_r);
    assign in_range = (exp_ref >= exp_sum_t'(1)) && (exp_ref <= exp_sum_t'(2**`FP_EXP_W - 2));
    assign bad_exp  = !s2_special && in_range && (exp_z != exp_ref[`FP_EXP_W-1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            check_error <= 1'b0;
        end else if (s2_valid && (bad_booth || bad_norm || bad_lead ||
                                  bad_sign || bad_round || bad_exp)) begin
            check_error <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/fp_mul_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fp_mul_settings.svh"

module fp_mul_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  fp_mul_pkg::fp32_t  fp_x,
    input  fp_mul_pkg::fp32_t  fp_y,
    input  fp_mul_pkg::rmode_e r_mode,
    output logic               out_valid,
    output fp_mul_pkg::fp32_t  fp_z,
    output logic               ovrf,
    output logic               udrf,
    output logic               check_error
);

    import fp_mul_pkg::*;

    // stage 1
    logic     s1_valid;
    fp32_t    s1_x;
    fp32_t    s1_y;
    rmode_e   s1_rmode;
    logic     s1_x_zero;
    logic     s1_x_inf;
    logic     s1_x_nan;
    logic     s1_y_zero;
    logic     s1_y_inf;
    logic     s1_y_nan;

    // stage 2
    logic      s2_valid;
    sig_prod_t s2_prod;
    fp32_t     s2_x;
    fp32_t     s2_y;
    rmode_e    s2_rmode;
    exp_sum_t  s2_exp_sum;
    logic      s2_sign;
    logic      s2_special;
    fp32_t     s2_special_val;

    // stage 3 combinational
    sig_norm_t             norm_sig;
    logic                  norm_n;
    logic                  norm_r;
    logic [`FP_FRAC_W-1:0] frc_z;
    logic [`FP_EXP_W-1:0]  exp_z;

    fp_mul_unpack u_unpack (
        .clk(clk), .rst(rst), .in_valid(in_valid),
        .fp_x(fp_x), .fp_y(fp_y), .r_mode(r_mode),
        .s1_valid(s1_valid), .s1_x(s1_x), .s1_y(s1_y), .s1_rmode(s1_rmode),
        .s1_x_zero(s1_x_zero), .s1_x_inf(s1_x_inf), .s1_x_nan(s1_x_nan),
        .s1_y_zero(s1_y_zero), .s1_y_inf(s1_y_inf), .s1_y_nan(s1_y_nan)
    );

    fp_mul_booth u_booth (
        .clk(clk), .rst(rst), .s1_valid(s1_valid),
        .frc_x(s1_x.frac), .frc_y(s1_y.frac),
        .s2_valid(s2_valid), .s2_prod(s2_prod)
    );

    fp_mul_exp u_exp (
        .clk(clk), .rst(rst), .s1_x(s1_x), .s1_y(s1_y), .s1_rmode(s1_rmode),
        .s1_x_zero(s1_x_zero), .s1_x_inf(s1_x_inf), .s1_x_nan(s1_x_nan),
        .s1_y_zero(s1_y_zero), .s1_y_inf(s1_y_inf), .s1_y_nan(s1_y_nan),
        .s2_x(s2_x), .s2_y(s2_y), .s2_rmode(s2_rmode), .s2_exp_sum(s2_exp_sum),
        .s2_sign(s2_sign), .s2_special(s2_special), .s2_special_val(s2_special_val)
    );

    fp_mul_norm u_norm (
        .s2_prod(s2_prod), .norm_sig(norm_sig), .norm_n(norm_n)
    );

    fp_mul_round u_round (
        .clk(clk), .rst(rst), .s2_valid(s2_valid),
        .norm_sig(norm_sig), .norm_n(norm_n), .s2_exp_sum(s2_exp_sum),
        .s2_sign(s2_sign), .s2_rmode(s2_rmode),
        .s2_special(s2_special), .s2_special_val(s2_special_val),
        .out_valid(out_valid), .fp_z(fp_z), .ovrf(ovrf), .udrf(udrf),
        .frc_z(frc_z), .norm_r(norm_r), .exp_z(exp_z)
    );

    fp_mul_checker u_checker (
        .clk(clk), .rst(rst), .s2_valid(s2_valid),
        .s2_x(s2_x), .s2_y(s2_y), .s2_prod(s2_prod),
        .norm_sig(norm_sig), .norm_n(norm_n), .norm_r(norm_r),
        .s2_sign(s2_sign), .s2_special(s2_special),
        .frc_z(frc_z), .exp_z(exp_z), .check_error(check_error)
    );

endmodule

`default_nettype wire

/* sim/tb_fp_mul.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fp_mul_settings.svh"

module tb_fp_mul;

    import fp_mul_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 2000;
    localparam int N_DIRECTED   = 64;
    // directed ops may sit behind gaps and drains while random ones run back to back
    localparam int MAX_CYCLES   = RESET_CYCLES + N_RANDOM + 8 * N_DIRECTED
                                + `FP_LATENCY + 200;

    logic   clk;
    logic   rst;
    logic   in_valid;
    fp32_t  fp_x;
    fp32_t  fp_y;
    rmode_e r_mode;
    logic   out_valid;
    fp32_t  fp_z;
    logic   ovrf;
    logic   udrf;
    logic   check_error;

    int          cyc = 0;
    int          n_tests = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          test_checks;
    int          test_errors;
    string       cur_test;
    logic [31:0] rng = 32'h640d;

    // expected results, in issue order
    fp32_t z_q[$];
    logic  ov_q[$];
    logic  ud_q[$];
    string name_q[$];
    int    issue_q[$];

    fp_mul_top u_dut (
        .clk(clk), .rst(rst), .in_valid(in_valid),
        .fp_x(fp_x), .fp_y(fp_y), .r_mode(r_mode),
        .out_valid(out_valid), .fp_z(fp_z), .ovrf(ovrf), .udrf(udrf),
        .check_error(check_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic fp32_t ref_fp_mul(input fp32_t x, input fp32_t y,
                                         input logic [2:0] mode,
                                         output logic ov, output logic ud);
        logic        sign;
        logic        x_zero;
        logic        x_inf;
        logic        x_nan;
        logic        y_zero;
        logic        y_inf;
        logic        y_nan;
        logic [47:0] prod;
        logic [23:0] mant;
        logic        guard;
        logic        rest;
        logic        inc;
        int          e;
        fp32_t       z;
        ov     = 1'b0;
        ud     = 1'b0;
        sign   = x.sign ^ y.sign;
        x_zero = (x.exp == 8'h00);
        x_inf  = (x.exp == 8'hff) && (x.frac == 23'h0);
        x_nan  = (x.exp == 8'hff) && (x.frac != 23'h0);
        y_zero = (y.exp == 8'h00);
        y_inf  = (y.exp == 8'hff) && (y.frac == 23'h0);
        y_nan  = (y.exp == 8'hff) && (y.frac != 23'h0);
        if (x_nan || y_nan || ((x_inf || y_inf) && (x_zero || y_zero))) begin
            z = `FP_QNAN;
        end else if (x_inf || y_inf) begin
            z = {sign, 8'hff, 23'h0};
        end else if (x_zero || y_zero) begin
            z = {sign, 31'h0};
        end else begin
            prod = {24'h0, 1'b1, x.frac} * {24'h0, 1'b1, y.frac};
            e    = int'(x.exp) + int'(y.exp) - `FP_EXP_BIAS;
            if (prod[47]) begin
                mant = prod[47:24];
                guard = prod[23];
                rest = |prod[22:0];
                e = e + 1;
            end else begin
                mant = prod[46:23];
                guard = prod[22];
                rest = |prod[21:0];
            end
            case (mode)
                3'b000:  inc = guard && (rest || mant[0]);
                3'b010:  inc = sign && (guard || rest);
                3'b011:  inc = !sign && (guard || rest);
                3'b100:  inc = guard;
                default: inc = 1'b0;
            endcase
            if (inc && (mant == 24'hffffff)) begin
                mant = 24'h800000;
                e = e + 1;
            end else if (inc) begin
                mant = mant + 24'd1;
            end
            if (e >= 255) begin
                ov = 1'b1;
                z = {sign, 8'hff, 23'h0};
            end else if (e <= 0) begin
                ud = 1'b1;
                z = {sign, 31'h0};
            end else begin
                z = {sign, e[7:0], mant[22:0]};
            end
        end
        return z;
    endfunction

    task automatic check_result(input string name, input fp32_t expected, input fp32_t actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED %s: expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        n_checks++;
        if (actual != expected) begin
            n_errors++;
            $display("FAILED %s latency: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic send_expect(input fp32_t x, input fp32_t y, input rmode_e mode,
                               input string name, input fp32_t z, input logic ov,
                               input logic ud);
        @(posedge clk);
        #2;
        fp_x     = x;
        fp_y     = y;
        r_mode   = mode;
        in_valid = 1'b1;
        z_q.push_back(z);
        ov_q.push_back(ov);
        ud_q.push_back(ud);
        name_q.push_back(name);
        // cycle in which the strobe is driven
        issue_q.push_back(cyc);
    endtask

    task automatic send(input fp32_t x, input fp32_t y, input rmode_e mode, input string name);
        fp32_t z;
        logic  ov;
        logic  ud;
        z = ref_fp_mul(x, y, mode, ov, ud);
        send_expect(x, y, mode, name, z, ov, ud);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            in_valid = 1'b0;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_checks = n_checks;
        test_errors = n_errors;
    endtask

    task automatic finish_test();
        idle_cycles(1);
        while (z_q.size() != 0) begin
            idle_cycles(1);
        end
        // check_error lags one cycle behind stage 3
        idle_cycles(1);
        n_tests++;
        $display("test %s: %0d checks, %0d errors", cur_test,
                 n_checks - test_checks, n_errors - test_errors);
    endtask

    task automatic rand_operand(output fp32_t v);
        rng = xorshift(rng);
        v = rng;
        rng = xorshift(rng);
        // most exponents near the bias so products stay in range
        if (rng[1:0] != 2'b00) begin
            v.exp = 8'd64 + {1'b0, rng[8:2]};
        end
    endtask

    initial begin : compare
        string name;
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (out_valid === 1'b1 && z_q.size() != 0) begin
                name = name_q.pop_front();
                check_result({name, " z"}, z_q.pop_front(), fp_z);
                check_flag({name, " ovrf"}, ov_q.pop_front(), ovrf);
                check_flag({name, " udrf"}, ud_q.pop_front(), udrf);
                check_flag({name, " check_error"}, 1'b0, check_error);
                check_latency(name, `FP_LATENCY, cyc - issue_q.pop_front());
            end else if (out_valid !== 1'b0) begin
                n_errors++;
                $display("out_valid high at cycle %0d with no operation pending", cyc);
            end
        end
    end

    initial begin : watchdog
        repeat (MAX_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, results never drained", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        fp32_t       a;
        fp32_t       b;
        fp32_t       nx[4];
        fp32_t       ny[4];
        logic [31:0] m;
        rst      = 1'b1;
        in_valid = 1'b0;
        fp_x     = '0;
        fp_y     = '0;
        r_mode   = RNE;
        nx = '{32'h3fc00000, 32'h3fffffff, 32'hbfffffff, 32'h3f7fffff};
        ny = '{32'hc0300000, 32'h3fffffff, 32'h3fffffff, 32'h3f800001};
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        begin_test("exact_products");
        for (int i = 0; i < 8; i++) begin
            send_expect(32'h40400000, 32'h40400000, rmode_e'(i[2:0]),
                        $sformatf("3.0*3.0 mode %0d", i), 32'h41100000, 1'b0, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 5; j++) begin
                send(nx[i], ny[i], rmode_e'(j[2:0]), $sformatf("normal %0d mode %0d", i, j));
            end
        end
        finish_test();

        begin_test("special_cases");
        send(32'h00000001, 32'h3f800000, RNE, "subnormal*one");
        send(32'h80400000, 32'h40000000, RUP, "neg subnormal*two");
        send(32'h00000000, 32'hc0000000, RDN, "zero*neg two");
        send(32'h7f800000, 32'hc0000000, RNE, "inf*neg two");
        send(32'hff800000, 32'hff800000, RTZ, "neg inf*neg inf");
        send(32'hff800000, 32'h00000000, RNE, "inf*zero");
        send(32'h7f800000, 32'h00000005, RMM, "inf*subnormal");
        send(32'h7f800001, 32'h3f800000, RNE, "snan*one");
        send(32'h3f800000, 32'hffc00000, RUP, "one*qnan");
        send(32'h7fc00000, 32'h7f800000, RDN, "nan*inf");
        finish_test();

        begin_test("overflow_underflow");
        for (int j = 0; j < 5; j++) begin
            send(32'h7f000000, 32'hff000000, rmode_e'(j[2:0]), $sformatf("ovf mode %0d", j));
        end
        send(32'h7f7fffff, 32'h3f800001, RTZ, "max*one plus ulp");
        send(32'h7f7fffff, 32'h3f800000, RUP, "max*one");
        send(32'h00800000, 32'h00800000, RNE, "min*min");
        send(32'h80800000, 32'h3f000000, RDN, "neg min*half");
        send(32'h00800000, 32'h3f800000, RNE, "min*one");
        finish_test();

        begin_test("latency_throughput");
        for (int k = 0; k < 3; k++) begin
            send(32'h40400000 + k, 32'hbf800000, RNE, $sformatf("isolated %0d", k));
            idle_cycles(5);
        end
        send(32'h3fc00000, 32'h40000000, RNE, "burst 0");
        send(32'h40000000, 32'h40400000, RTZ, "burst 1");
        send(32'h7f800000, 32'h3f800000, RUP, "burst 2");
        send(32'h00000000, 32'h3f800000, RDN, "burst 3");
        finish_test();

        begin_test("random");
        for (int i = 0; i < N_RANDOM; i++) begin
            rand_operand(a);
            rand_operand(b);
            rng = xorshift(rng);
            m = rng;
            send(a, b, rmode_e'(m[2:0]), $sformatf("random %0d", i));
        end
        finish_test();

        check_flag("final check_error", 1'b0, check_error);
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/fp_mul_pkg.sv
hdl/fp_mul_unpack.sv
hdl/fp_mul_booth.sv
hdl/fp_mul_exp.sv
hdl/fp_mul_norm.sv
hdl/fp_mul_round.sv
hdl/fp_mul_checker.sv
hdl/fp_mul_top.sv
sim/tb_fp_mul.sv

/* Makefile */
TOP = tb_fp_mul

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		-f compile.f --top-module $(TOP) -o V$(TOP)

# status follows the search for the pass line
run: compile
	./obj_dir/V$(TOP) | awk '{ print } /^TEST PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
